// ==== mm_tile.f ====
src/mm_tile_pkg.sv
src/mm_step_counter.sv
src/mm_w_buffer.sv
src/mm_mac_array.sv
src/mm_tile_fsm.sv
src/mm_tile_top.sv
testbench/tb_mm_tile.sv

// ==== testbench/tb_mm_tile.sv ====
// Self-checking testbench for mm_tile_top that runs random tiles against a dot-product model
`timescale 1ns/10ps

module tb_mm_tile import mm_tile_pkg::*; ();

  localparam int          CLK_HALF        = 2;                          // 4 ns period
  localparam int          RESET_CYCLES    = 8;
  localparam int          NUM_TILES       = 200;
  localparam int          TILE_CYCLES     = ARRAY_H * 4 + DEPTH_D + 10; // Worst case per tile
  localparam int          WATCHDOG_CYCLES = NUM_TILES * TILE_CYCLES + RESET_CYCLES;
  localparam int          CFG_W           = $bits(tile_cfg_t);
  localparam logic [31:0] SEED            = 32'h8e28332d;

  logic                          clk_i;
  logic                          rst_ni;
  logic                          start_i;
  tile_cfg_t                     cfg_i;
  logic [ROW_BUS_W-1:0]          x_data_i;
  logic                          w_valid_i;
  logic [ROW_BUS_W-1:0]          w_data_i;
  logic                          busy_o;
  logic                          done_o;
  logic [ARRAY_H-1:0][ACC_W-1:0] result_o;

  logic [31:0]          rng_state;          // Xorshift state
  logic [ROW_BUS_W-1:0] w_rows [ARRAY_H];   // Weights of the running tile
  logic [ROW_BUS_W-1:0] x_vec;              // x of the running tile
  logic [ACC_W-1:0]     expected [ARRAY_H]; // Model results

  mm_tile_top mm_tile_top_i (
    .clk_i     ( clk_i     ),
    .rst_ni    ( rst_ni    ),
    .start_i   ( start_i   ),
    .cfg_i     ( cfg_i     ),
    .x_data_i  ( x_data_i  ),
    .w_valid_i ( w_valid_i ),
    .w_data_i  ( w_data_i  ),
    .busy_o    ( busy_o    ),
    .done_o    ( done_o    ),
    .result_o  ( result_o  )
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_HALF) clk_i = ~clk_i;
  end

  // Watchdog sized for the longest possible run
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Simulation timed out before all tiles finished");
    $display("Test failed");
    $fatal(1, "Watchdog expired");
  end

  // 32-bit xorshift
  function automatic logic [31:0] next_rand();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  function automatic logic [ROW_BUS_W-1:0] rand_row();
    return {next_rand(), next_rand()}; // Eight random elements
  endfunction

  task automatic check_value(input string name, input logic [63:0] exp_val,
                             input logic [63:0] act_val);
    if (exp_val !== act_val) begin
      $display("[ERROR] %s: expected %0d, actual %0d", name, exp_val, act_val);
      $display("Test failed");
      $fatal(1, "Value mismatch");
    end
  endtask

  task automatic report_failure(input string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1, "Run aborted");
  endtask

  // Dot product per row masked by row count and depth
  task automatic compute_model(input int rows_n, input int cols_n);
    for (int h = 0; h < ARRAY_H; h++) begin
      expected[h] = '0;
      if (h < rows_n) begin
        for (int d = 0; d < cols_n; d++) begin
          expected[h] += ACC_W'(w_rows[h][d*ELEM_W +: ELEM_W]) *
                         ACC_W'(x_vec[d*ELEM_W +: ELEM_W]);
        end
      end
    end
  endtask

  task automatic check_results(input string what, input int tile);
    for (int h = 0; h < ARRAY_H; h++) begin
      check_value($sformatf("tile %0d lane %0d %s", tile, h, what), expected[h], result_o[h]);
    end
  endtask

  // One tile entered and left on a falling edge
  task automatic run_tile(input int tile);
    tile_cfg_t   cfg;
    int          rows_n;
    int          cols_n;
    int          gap;
    int          edges;
    int          idle_n;
    logic [31:0] rnd;
    cfg.rows_lftovr = (tile < 10) ? '0 : ROWS_W'(next_rand()); // Full tiles first
    cfg.cols_lftovr = (tile < 10) ? '0 : COLS_W'(next_rand());
    rows_n = (cfg.rows_lftovr == 0) ? ARRAY_H : int'(cfg.rows_lftovr);
    cols_n = (cfg.cols_lftovr == 0) ? DEPTH_D : int'(cfg.cols_lftovr);
    x_vec  = rand_row();
    for (int h = 0; h < ARRAY_H; h++) begin
      w_rows[h] = rand_row();                  // Unused rows still random
    end
    compute_model(rows_n, cols_n);

    start_i   = 1'b1;
    cfg_i     = cfg;
    x_data_i  = x_vec;
    w_valid_i = 1'b0;
    @(negedge clk_i);
    start_i  = 1'b0;
    cfg_i    = tile_cfg_t'(CFG_W'(next_rand())); // Must not reach the tile
    x_data_i = rand_row();

    // Load phase with random gaps and stray starts
    for (int r = 0; r < rows_n; r++) begin
      check_value("busy_o during load", 1, busy_o);
      check_value("done_o during load", 0, done_o);
      gap = int'(next_rand() % 4);
      for (int g = 0; g < gap; g++) begin
        rnd       = next_rand();
        start_i   = (rnd[1:0] == 2'b00);      // Ignored while busy
        w_valid_i = 1'b0;
        w_data_i  = rand_row();
        @(negedge clk_i);
        check_value("busy_o during load gap", 1, busy_o);
        check_value("done_o during load gap", 0, done_o);
      end
      start_i   = 1'b0;
      w_valid_i = 1'b1;
      w_data_i  = w_rows[r];
      @(negedge clk_i);
      w_valid_i = 1'b0;
    end

    // Shift phase counting edges after the last row
    edges = 0;
    while (!done_o) begin
      if (edges > 2 * DEPTH_D) begin
        report_failure($sformatf("Tile %0d never raised done_o", tile));
      end
      check_value("busy_o during shift", 1, busy_o);
      rnd       = next_rand();
      start_i   = (rnd[1:0] == 2'b00);        // Stray start
      w_valid_i = rnd[2];                     // Stray row strobe
      w_data_i  = rand_row();
      @(negedge clk_i);
      edges++;
    end
    start_i   = 1'b0;
    w_valid_i = 1'b0;
    check_value("done_o latency", DEPTH_D, edges);
    check_value("busy_o at done", 0, busy_o);
    check_results("result", tile);

    // Idle with stray strobes while results hold
    idle_n = 1 + int'(next_rand() % 3);
    for (int i = 0; i < idle_n; i++) begin
      rnd       = next_rand();
      w_valid_i = rnd[0];
      w_data_i  = rand_row();
      @(negedge clk_i);
      check_value("done_o width", 0, done_o);
      check_value("busy_o in idle", 0, busy_o);
      check_results("held result", tile);
    end
    w_valid_i = 1'b0;
  endtask

  initial begin
    rng_state = SEED;
    rst_ni    = 1'b0;
    start_i   = 1'b0;
    cfg_i     = '0;
    x_data_i  = '0;
    w_valid_i = 1'b0;
    w_data_i  = '0;
    repeat (RESET_CYCLES) @(negedge clk_i);
    check_value("busy_o in reset", 0, busy_o);
    check_value("done_o in reset", 0, done_o);
    for (int h = 0; h < ARRAY_H; h++) begin
      check_value($sformatf("result_o lane %0d in reset", h), 0, result_o[h]);
    end
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_value("busy_o after reset", 0, busy_o);
    check_value("done_o after reset", 0, done_o);
    for (int h = 0; h < ARRAY_H; h++) begin
      check_value($sformatf("result_o lane %0d after reset", h), 0, result_o[h]);
    end

    for (int t = 0; t < NUM_TILES; t++) begin
      run_tile(t);
    end

    $display("Test completed successfully");
    $finish;
  end

endmodule : tb_mm_tile

// ==== src/mm_tile_top.sv ====
// Top level of the mm_tile engine; connects the sequencer, step counter, weight buffer and lanes
`timescale 1ns/10ps

module mm_tile_top import mm_tile_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          start_i,  // Tile start pulse
  input  tile_cfg_t                     cfg_i,    // Sampled with start_i
  input  logic [ROW_BUS_W-1:0]          x_data_i, // Sampled with start_i
  input  logic                          w_valid_i,
  input  logic [ROW_BUS_W-1:0]          w_data_i, // Sampled with w_valid_i
  output logic                          busy_o,
  output logic                          done_o,   // One cycle at tile end
  output logic [ARRAY_H-1:0][ACC_W-1:0] result_o
);

  logic                           cnt_clear;
  logic                           cnt_en;
  logic [CNT_W-1:0]               cnt_limit;
  logic [CNT_W-1:0]               count;    // Doubles as the row pointer
  logic                           cnt_last;
  w_buffer_ctrl_t                 w_ctrl;
  mac_ctrl_t                      mac_ctrl;
  logic [ARRAY_H-1:0][ELEM_W-1:0] w_col;    // Buffer head column

  mm_tile_fsm mm_tile_fsm_i (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .start_i     ( start_i   ),
    .cfg_i       ( cfg_i     ),
    .w_valid_i   ( w_valid_i ),
    .last_i      ( cnt_last  ),
    .cnt_clear_o ( cnt_clear ),
    .cnt_en_o    ( cnt_en    ),
    .cnt_limit_o ( cnt_limit ),
    .w_ctrl_o    ( w_ctrl    ),
    .mac_ctrl_o  ( mac_ctrl  ),
    .busy_o      ( busy_o    ),
    .done_o      ( done_o    )
  );

  mm_step_counter mm_step_counter_i (
    .clk_i   ( clk_i     ),
    .rst_ni  ( rst_ni    ),
    .clear_i ( cnt_clear ),
    .en_i    ( cnt_en    ),
    .limit_i ( cnt_limit ),
    .count_o ( count     ),
    .last_o  ( cnt_last  )
  );

  // Accepted start clears the buffer together with the lane init
  mm_w_buffer mm_w_buffer_i (
    .clk_i      ( clk_i         ),
    .rst_ni     ( rst_ni        ),
    .clear_i    ( mac_ctrl.init ),
    .ctrl_i     ( w_ctrl        ),
    .row_i      ( count         ),
    .w_buffer_i ( w_data_i      ),
    .w_buffer_o ( w_col         )
  );

  mm_mac_array mm_mac_array_i (
    .clk_i   ( clk_i    ),
    .rst_ni  ( rst_ni   ),
    .ctrl_i  ( mac_ctrl ),
    .x_i     ( x_data_i ),
    .w_col_i ( w_col    ),
    .acc_o   ( result_o )
  );

endmodule : mm_tile_top

// ==== src/mm_tile_fsm.sv ====
// Tile sequencer stepping through idle, load, shift and done; drives all datapath strobes
`timescale 1ns/10ps

module mm_tile_fsm import mm_tile_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             start_i,     // Honoured only in idle
  input  tile_cfg_t        cfg_i,
  input  logic             w_valid_i,   // Row strobe, honoured only in load
  input  logic             last_i,      // From the step counter
  output logic             cnt_clear_o,
  output logic             cnt_en_o,
  output logic [CNT_W-1:0] cnt_limit_o,
  output w_buffer_ctrl_t   w_ctrl_o,
  output mac_ctrl_t        mac_ctrl_o,
  output logic             busy_o,
  output logic             done_o
);

  typedef enum logic [1:0] {
    IDLE,  // Waiting for start
    LOAD,  // Collecting W rows
    SHIFT, // DEPTH_D accumulate steps
    DONE   // One-cycle result strobe
  } state_e;

  state_e           state_q, state_d;
  tile_cfg_t        cfg_q;   // Config of the running tile
  logic [CNT_W-1:0] row_cnt; // Rows expected in load

  // Zero leftover means all ARRAY_H rows
  assign row_cnt = (cfg_q.rows_lftovr == '0) ? CNT_W'(ARRAY_H) : CNT_W'(cfg_q.rows_lftovr);

  always_comb begin
    state_d              = state_q;
    cnt_clear_o          = 1'b0;
    cnt_en_o             = 1'b0;
    cnt_limit_o          = row_cnt;           // Load limit by default
    w_ctrl_o.load        = 1'b0;
    w_ctrl_o.shift       = 1'b0;
    w_ctrl_o.cols_lftovr = cfg_q.cols_lftovr;
    mac_ctrl_o.init      = 1'b0;
    mac_ctrl_o.acc       = 1'b0;
    unique case (state_q)
      IDLE: begin
        if (start_i) begin
          mac_ctrl_o.init = 1'b1;             // Also clears the buffer in the top
          cnt_clear_o     = 1'b1;
          state_d         = LOAD;
        end
      end
      LOAD: begin
        w_ctrl_o.load = w_valid_i;            // One row per strobe
        cnt_en_o      = w_valid_i;
        if (last_i) begin
          cnt_clear_o = 1'b1;                 // Reuse counter for shifts
          state_d     = SHIFT;
        end
      end
      SHIFT: begin
        cnt_limit_o    = CNT_W'(DEPTH_D);
        cnt_en_o       = 1'b1;
        w_ctrl_o.shift = 1'b1;
        mac_ctrl_o.acc = 1'b1;
        if (last_i) begin
          cnt_clear_o = 1'b1;
          state_d     = DONE;
        end
      end
      DONE: begin
        state_d = IDLE;                       // Results stay in the lanes
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      cfg_q   <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == IDLE && start_i) begin
        cfg_q <= cfg_i;                       // Sampled with start
      end
    end
  end

  assign busy_o = (state_q == LOAD) || (state_q == SHIFT); // Low again in done
  assign done_o = (state_q == DONE);

endmodule : mm_tile_fsm

// ==== src/mm_mac_array.sv ====
// x shift register and ARRAY_H multiply-accumulate lanes that form the tile result
`timescale 1ns/10ps

module mm_mac_array import mm_tile_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  mac_ctrl_t                     ctrl_i,
  input  logic [ROW_BUS_W-1:0]          x_i,     // x vector, taken on init
  input  logic [ARRAY_H-1:0][ELEM_W-1:0] w_col_i, // Head column of the weight buffer
  output logic [ARRAY_H-1:0][ACC_W-1:0] acc_o    // One dot product per lane
);

  logic [DEPTH_D-1:0][ELEM_W-1:0]   x_q;   // x vector with the head at element 0
  logic [ARRAY_H-1:0][ACC_W-1:0]    acc_q; // Running sums
  logic [ARRAY_H-1:0][2*ELEM_W-1:0] prod;  // Per-lane product this step

  // Every lane multiplies by the same x element
  always_comb begin
    for (int h = 0; h < ARRAY_H; h++) begin
      prod[h] = w_col_i[h] * x_q[0]; // Full 16-bit product
    end
  end

  // x register loaded on init and shifted on acc
  always_ff @(posedge clk_i) begin
    if (ctrl_i.init) begin
      x_q <= x_i;                                     // Sample x with start
    end else if (ctrl_i.acc) begin
      x_q <= {{ELEM_W{1'b0}}, x_q[DEPTH_D-1:1]};      // Next element to the head
    end
  end

  // Accumulators cleared per tile
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q <= '0;
    end else if (ctrl_i.init) begin
      acc_q <= '0;                                    // New tile
    end else if (ctrl_i.acc) begin
      for (int h = 0; h < ARRAY_H; h++) begin
        acc_q[h] <= acc_q[h] + ACC_W'(prod[h]);       // Never overflows at 8 steps
      end
    end
  end

  assign acc_o = acc_q; // Held between tiles

endmodule : mm_mac_array

// ==== src/mm_w_buffer.sv ====
// Weight buffer holding one W tile that is written row by row and shifted out by column
`timescale 1ns/10ps

module mm_w_buffer import mm_tile_pkg::*; (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           clear_i,    // Zero the whole tile
  input  w_buffer_ctrl_t                 ctrl_i,
  input  logic [CNT_W-1:0]               row_i,      // Row pointer for load
  input  logic [ROW_BUS_W-1:0]           w_buffer_i, // Incoming W row
  output logic [ARRAY_H-1:0][ELEM_W-1:0] w_buffer_o  // Head column, one element per row
);

  logic [ARRAY_H-1:0][DEPTH_D-1:0][ELEM_W-1:0] w_buffer_q; // Row-major tile storage
  logic [CNT_W-1:0]                            depth;      // Valid columns of this tile

  // Zero leftover means a full row
  assign depth = (ctrl_i.cols_lftovr == '0) ? CNT_W'(DEPTH_D) : CNT_W'(ctrl_i.cols_lftovr);

  // Storage where clear beats load beats shift
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      w_buffer_q <= '0;
    end else if (clear_i) begin
      w_buffer_q <= '0;                                  // Fresh tile
    end else if (ctrl_i.load) begin
      for (int h = 0; h < ARRAY_H; h++) begin
        if (row_i == CNT_W'(h)) begin                    // Only the addressed row
          for (int d = 0; d < DEPTH_D; d++) begin
            w_buffer_q[h][d] <= (CNT_W'(d) < depth) ?
                                w_buffer_i[d*ELEM_W +: ELEM_W] : '0; // Mask past depth
          end
        end
      end
    end else if (ctrl_i.shift) begin
      for (int h = 0; h < ARRAY_H; h++) begin
        w_buffer_q[h] <= {{ELEM_W{1'b0}}, w_buffer_q[h][DEPTH_D-1:1]}; // Toward element 0
      end
    end
  end

  // Element 0 of every row feeds its lane
  always_comb begin
    for (int h = 0; h < ARRAY_H; h++) begin
      w_buffer_o[h] = w_buffer_q[h][0];
    end
  end

endmodule : mm_w_buffer

// ==== src/mm_step_counter.sv ====
// Clearable step counter shared by the load and shift phases of the tile sequencer
`timescale 1ns/10ps

module mm_step_counter import mm_tile_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             clear_i, // Back to zero, wins over en_i
  input  logic             en_i,    // Count one step
  input  logic [CNT_W-1:0] limit_i, // Steps in the current phase
  output logic [CNT_W-1:0] count_o, // Steps taken so far
  output logic             last_o   // This step is the final one
);

  logic [CNT_W-1:0] count_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else if (clear_i) begin
      count_q <= '0;
    end else if (en_i) begin
      count_q <= count_q + CNT_W'(1);
    end
  end

  // Only an enabled step can be the last one
  assign last_o  = en_i && (count_q == limit_i - CNT_W'(1));
  assign count_o = count_q;

endmodule : mm_step_counter

// ==== src/mm_tile_pkg.sv ====
// Shared sizes and control structs for the mm_tile engine, imported by every RTL module
package mm_tile_pkg;

  // Datapath sizes
  localparam int unsigned ELEM_W    = 8;                              // Unsigned element width
  localparam int unsigned ARRAY_H   = 4;                              // Rows of W, MAC lanes
  localparam int unsigned DEPTH_D   = 8;                              // Columns per row
  localparam int unsigned ROW_BUS_W = DEPTH_D * ELEM_W;               // One W row or x vector
  localparam int unsigned ACC_W     = 2 * ELEM_W + $clog2(DEPTH_D) + 1; // Eight 16-bit products

  // Control field widths
  localparam int unsigned CNT_W  = $clog2(DEPTH_D) + 1;  // Counts up to DEPTH_D
  localparam int unsigned ROWS_W = $clog2(ARRAY_H);      // Row leftover, 0 means full
  localparam int unsigned COLS_W = $clog2(DEPTH_D);      // Column leftover, 0 means full

  // Tile configuration, sampled with start
  typedef struct packed {
    logic [ROWS_W-1:0] rows_lftovr; // Rows to load, 0 selects ARRAY_H
    logic [COLS_W-1:0] cols_lftovr; // Valid columns, 0 selects DEPTH_D
  } tile_cfg_t;

  // Weight buffer strobes
  typedef struct packed {
    logic              load;        // Write one row from the bus
    logic              shift;       // Move all rows toward element 0
    logic [COLS_W-1:0] cols_lftovr; // Column mask for the row write
  } w_buffer_ctrl_t;

  // MAC lane strobes
  typedef struct packed {
    logic init; // Load x, zero accumulators
    logic acc;  // Multiply-accumulate and shift x
  } mac_ctrl_t;

endpackage : mm_tile_pkg
